// File: Makefile
# Verilator build and run of the reset subsystem testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rst_subsys
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS: see $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/rst_cause_rec.sv
// Reset-cause recorder; latches why the core last left reset and counts debug resets.

module rst_cause_rec #(
    parameter int JTAG_CNT_W = rst_cfg_pkg::JTAG_CNT_W_DEF
) (
    input  logic                    clk,
    input  logic                    rst_ext_i,         // External reset, active low.
    input  logic                    rst_jtag_i,        // Debug reset request, active high.
    input  logic                    core_rst_n_i,      // Core reset from the controller.
    output rst_types_pkg::rst_cause_e cause_o,         // Cause of the last core reset.
    output logic [JTAG_CNT_W-1:0]   jtag_cnt_o         // Debug resets since ext reset.
);

    import rst_types_pkg::*;

    // **************************************************
    // State, cleared only by the external reset
    // **************************************************

    logic            core_rst_q;                       // Core reset, one clock late.
    logic            jtag_q;                           // Debug request, one clock late.
    logic            jtag_seen_q;                      // Request seen since last release.
    rst_cause_e      cause_q;                          // Recorded cause.
    logic [JTAG_CNT_W-1:0] cnt_q;                      // Debug request count.

    logic core_rel;                                    // Core reset just released.
    logic jtag_rise;                                   // New debug request.

    assign core_rel  = core_rst_n_i & ~core_rst_q;     // Rising edge of core_rst_n_i.
    assign jtag_rise = rst_jtag_i & ~jtag_q;           // Rising edge of rst_jtag_i.

    // Edge-detect history.
    always_ff @(posedge clk) begin
        if (!rst_ext_i) begin
            core_rst_q <= 1'b0;                         // Core is in reset here.
            jtag_q     <= 1'b0;
        end else begin
            core_rst_q <= core_rst_n_i;
            jtag_q     <= rst_jtag_i;
        end
    end

    // Cause capture at each core release.
    always_ff @(posedge clk) begin
        if (!rst_ext_i) begin
            jtag_seen_q <= 1'b0;
            cause_q     <= CAUSE_NONE;                  // Nothing released yet.
        end else if (core_rel) begin
            cause_q     <= jtag_seen_q ? CAUSE_JTAG : CAUSE_EXT;
            jtag_seen_q <= rst_jtag_i;                  // A request now belongs to next reset.
        end else if (rst_jtag_i) begin
            jtag_seen_q <= 1'b1;                        // Remember the debug request.
        end
    end

    // Saturating debug reset counter.
    always_ff @(posedge clk) begin
        if (!rst_ext_i) begin
            cnt_q <= '0;
        end else if (jtag_rise && (cnt_q != '1)) begin
            cnt_q <= cnt_q + 1'b1;                      // Stops at all ones.
        end
    end

    assign cause_o    = cause_q;
    assign jtag_cnt_o = cnt_q;

endmodule : rst_cause_rec

// File: rtl/rst_cfg_pkg.sv
// Default sizes of the reset chains and the debug counter; top level passes them down.

package rst_cfg_pkg;

    // **************************************************
    // External reset synchronizer
    // **************************************************

    // Flip-flops between rst_ext_i release and the synchronized release.
    localparam int SYNC_STAGES_DEF = 2;                 // Two stages for metastability margin.

    // **************************************************
    // Debug reset stretch
    // **************************************************

    // Depth of the shift register that holds the core in reset after a debug request.
    localparam int JTAG_RESET_FF_LEVELS_DEF = 5;        // Must stay at 2 or more.

    // **************************************************
    // Reset cause recorder
    // **************************************************

    // Width of the saturating counter of debug resets.
    localparam int JTAG_CNT_W_DEF = 4;                  // Saturates at 15.

endpackage : rst_cfg_pkg

// File: rtl/rst_ctrl.sv
// Reset controller; builds the core and debug resets from rst_ext_i and the debug request.

module rst_ctrl #(
    parameter int SYNC_STAGES          = rst_cfg_pkg::SYNC_STAGES_DEF,
    parameter int JTAG_RESET_FF_LEVELS = rst_cfg_pkg::JTAG_RESET_FF_LEVELS_DEF
) (
    input  logic clk,
    input  logic rst_ext_i,                            // External reset, active low.
    input  logic rst_jtag_i,                           // Debug reset request, active high.
    output logic core_rst_n_o,                         // Core reset, active low.
    output logic jtag_rst_n_o                          // Debug module reset, active low.
);

    // **************************************************
    // External reset synchronizer
    // **************************************************

    logic ext_rel;                                     // Synchronized external release.

    // A constant one walks through the chain once rst_ext_i goes high.
    tick_sync_chain #(
        .DP (SYNC_STAGES),
        .DW (1)
    ) ext_sync_inst (
        .clk     (clk),
        .rst_n_i (rst_ext_i),
        .din_i   (1'b1),
        .dout_o  (ext_rel)
    );

    // **************************************************
    // Debug reset stretch
    // **************************************************

    // Zeros mean reset; the top bit gates the core.
    logic [JTAG_RESET_FF_LEVELS-1:0] jtag_rst_q;

    always_ff @(posedge clk) begin
        if (!rst_ext_i) begin
            jtag_rst_q <= '1;                           // Preloaded so ext release never waits.
        end else if (rst_jtag_i) begin
            jtag_rst_q <= '0;                           // Request pulls core into reset.
        end else begin
            // Ones enter at bit 0 and reach the top after the full depth.
            jtag_rst_q <= {jtag_rst_q[JTAG_RESET_FF_LEVELS-2:0], 1'b1};
        end
    end

    // External reset has priority above since the request branch is only
    // reached when rst_ext_i is high.

    // **************************************************
    // Reset outputs
    // **************************************************

    assign core_rst_n_o = ext_rel & jtag_rst_q[JTAG_RESET_FF_LEVELS-1];  // Both must release.
    assign jtag_rst_n_o = ext_rel;                     // Debug side ignores rst_jtag_i.

endmodule : rst_ctrl

// File: rtl/rst_subsys_top.sv
// Reset subsystem top level; sets the sizes and joins the controller and the cause recorder.

module rst_subsys_top #(
    parameter int SYNC_STAGES          = rst_cfg_pkg::SYNC_STAGES_DEF,
    parameter int JTAG_RESET_FF_LEVELS = rst_cfg_pkg::JTAG_RESET_FF_LEVELS_DEF,
    parameter int JTAG_CNT_W           = rst_cfg_pkg::JTAG_CNT_W_DEF
) (
    input  logic                      clk,
    input  logic                      rst_ext_i,       // External reset, active low.
    input  logic                      rst_jtag_i,      // Debug reset request level.
    output logic                      core_rst_n_o,    // To the core.
    output logic                      jtag_rst_n_o,    // To the debug module.
    output rst_types_pkg::rst_cause_e cause_o,         // Readable by software.
    output logic [JTAG_CNT_W-1:0]     jtag_cnt_o       // Readable by software.
);

    // **************************************************
    // Reset generation
    // **************************************************

    rst_ctrl #(
        .SYNC_STAGES          (SYNC_STAGES),
        .JTAG_RESET_FF_LEVELS (JTAG_RESET_FF_LEVELS)
    ) rst_ctrl_inst (
        .clk          (clk),
        .rst_ext_i    (rst_ext_i),
        .rst_jtag_i   (rst_jtag_i),
        .core_rst_n_o (core_rst_n_o),
        .jtag_rst_n_o (jtag_rst_n_o)
    );

    // **************************************************
    // Reset cause and debug count
    // **************************************************

    // Watches the core reset it drives, so the cause lags the release by one clock.
    rst_cause_rec #(
        .JTAG_CNT_W (JTAG_CNT_W)
    ) rst_cause_rec_inst (
        .clk          (clk),
        .rst_ext_i    (rst_ext_i),
        .rst_jtag_i   (rst_jtag_i),
        .core_rst_n_i (core_rst_n_o),
        .cause_o      (cause_o),
        .jtag_cnt_o   (jtag_cnt_o)
    );

endmodule : rst_subsys_top

// File: rtl/rst_types_pkg.sv
// Reset-cause encoding shared by the recorder, the top level and the testbench.

package rst_types_pkg;

    // **************************************************
    // Cause of the most recent core reset
    // **************************************************

    // Two bits read by software after boot.
    typedef enum logic [1:0] {
        CAUSE_NONE = 2'd0,                              // Core not yet released.
        CAUSE_EXT  = 2'd1,                              // External or power-on reset.
        CAUSE_JTAG = 2'd2                               // Reset requested by the debugger.
    } rst_cause_e;

    // Value 2'd3 is never produced by the recorder.

endpackage : rst_types_pkg

// File: rtl/tick_sync_chain.sv
// Chain of DP synchronous-reset flip-flops that delays a DW-bit vector for reset release.

module tick_sync_chain #(
    parameter int DP = rst_cfg_pkg::SYNC_STAGES_DEF,   // Number of stages.
    parameter int DW = 1                               // Vector width.
) (
    input  logic          clk,
    input  logic          rst_n_i,                     // Synchronous, active low.
    input  logic [DW-1:0] din_i,                       // Value entering the chain.
    output logic [DW-1:0] dout_o                       // Value after DP clocks.
);

    // **************************************************
    // Stage registers
    // **************************************************

    logic [DW-1:0] stage_q [DP];                       // One entry per flip-flop.

    genvar i;

    generate
        for (i = 0; i < DP; i = i + 1) begin : g_stage
            if (i == 0) begin : g_first
                always_ff @(posedge clk) begin
                    if (!rst_n_i) begin
                        stage_q[0] <= '0;               // Held at zero in reset.
                    end else begin
                        stage_q[0] <= din_i;            // First stage samples input.
                    end
                end
            end else begin : g_next
                always_ff @(posedge clk) begin
                    if (!rst_n_i) begin
                        stage_q[i] <= '0;               // Whole chain clears together.
                    end else begin
                        stage_q[i] <= stage_q[i-1];     // Shift one stage per clock.
                    end
                end
            end
        end
    endgenerate

    // A constant one at din_i shows here exactly DP clocks after reset ends.
    assign dout_o = stage_q[DP-1];                     // Last stage drives output.

endmodule : tick_sync_chain

// File: sim/tb_rst_subsys.sv
// Testbench for the reset subsystem; drives reset and debug requests, checks against a model.

module tb_rst_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    import rst_cfg_pkg::*;
    import rst_types_pkg::*;

    localparam int RELEASE_TIMEOUT = 64;                        // Cycles allowed per release.
    localparam logic [JTAG_CNT_W_DEF-1:0] CNT_MAX = '1;         // Counter saturation value.

    // Expected state rebuilt every cycle from the timing rules.
    typedef struct packed {
        int                        sync_cnt;                    // Edges seen with rst_ext_i high.
        int                        hold_cnt;                    // Edges since last debug request.
        logic                      core_prev;                   // Core reset one clock ago.
        logic                      jtag_prev;                   // Request one clock ago.
        logic                      seen;                        // Request since last release.
        rst_cause_e                cause;
        logic [JTAG_CNT_W_DEF-1:0] cnt;
        logic                      core_n;                      // Expected core_rst_n_o.
        logic                      jtag_n;                      // Expected jtag_rst_n_o.
    } model_t;

    logic                      clk;
    logic                      rst_ext_i;
    logic                      rst_jtag_i;
    logic                      core_rst_n_o;
    logic                      jtag_rst_n_o;
    rst_cause_e                cause_o;
    logic [JTAG_CNT_W_DEF-1:0] jtag_cnt_o;

    logic [31:0] lfsr_q;                                        // Stimulus generator state.
    int          err_cnt;
    int          to_cnt;
    int          chk_cnt;
    model_t      exp_s;
    logic        chk_en = 1'b0;                                 // Model valid after first step.

    always #4 clk = ~clk;                                       // 8 ns period.

    rst_subsys_top rst_subsys_top_inst (
        .clk          (clk),
        .rst_ext_i    (rst_ext_i),
        .rst_jtag_i   (rst_jtag_i),
        .core_rst_n_o (core_rst_n_o),
        .jtag_rst_n_o (jtag_rst_n_o),
        .cause_o      (cause_o),
        .jtag_cnt_o   (jtag_cnt_o)
    );

    // **************************************************
    // Random source and reference model
    // **************************************************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;                    // Galois taps 32,30,26,25.
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(input int n, output int v);
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Next state from the inputs sampled at one rising edge.
    function automatic model_t model_step(input model_t s, input logic ext, input logic jtag);
        model_t n;
        logic   rel_now;
        n = s;
        if (!ext) begin
            n.sync_cnt  = 0;                                    // Release starts over.
            n.hold_cnt  = JTAG_RESET_FF_LEVELS_DEF;             // No debug stretch pending.
            n.core_prev = 1'b0;
            n.jtag_prev = 1'b0;
            n.seen      = 1'b0;
            n.cause     = CAUSE_NONE;
            n.cnt       = '0;
        end else begin
            rel_now = s.core_n & ~s.core_prev;                  // Core left reset last cycle.
            if (rel_now) begin
                n.cause = s.seen ? CAUSE_JTAG : CAUSE_EXT;
                n.seen  = jtag;                                 // Counts toward the next reset.
            end else if (jtag) begin
                n.seen = 1'b1;
            end
            if (jtag && !s.jtag_prev && (s.cnt != CNT_MAX)) begin
                n.cnt = s.cnt + 1'b1;                           // Count request rising edges.
            end
            n.core_prev = s.core_n;
            n.jtag_prev = jtag;
            if (s.sync_cnt < SYNC_STAGES_DEF) begin
                n.sync_cnt = s.sync_cnt + 1;
            end
            if (jtag) begin
                n.hold_cnt = 0;                                 // Stretch restarts on request.
            end else if (s.hold_cnt < JTAG_RESET_FF_LEVELS_DEF) begin
                n.hold_cnt = s.hold_cnt + 1;
            end
        end
        n.jtag_n = (n.sync_cnt >= SYNC_STAGES_DEF);
        n.core_n = n.jtag_n && (n.hold_cnt >= JTAG_RESET_FF_LEVELS_DEF);
        return n;
    endfunction

    task automatic report_fail(input string sig, input logic [31:0] got, input logic [31:0] want);
        $display("FAIL %s got 0x%0h exp 0x%0h at %0t", sig, got, want, $time);
        err_cnt++;
    endtask

    // **************************************************
    // Comparing process
    // **************************************************

    // Outputs are stable at the falling edge; inputs sampled here meet the next rising edge.
    always @(negedge clk) begin
        if (chk_en) begin
            chk_cnt++;
            if (core_rst_n_o !== exp_s.core_n) begin
                report_fail("core_rst_n_o", 32'(core_rst_n_o), 32'(exp_s.core_n));
            end
            if (jtag_rst_n_o !== exp_s.jtag_n) begin
                report_fail("jtag_rst_n_o", 32'(jtag_rst_n_o), 32'(exp_s.jtag_n));
            end
            if (cause_o !== exp_s.cause) begin
                report_fail("cause_o", 32'(cause_o), 32'(exp_s.cause));
            end
            if (jtag_cnt_o !== exp_s.cnt) begin
                report_fail("jtag_cnt_o", 32'(jtag_cnt_o), 32'(exp_s.cnt));
            end
        end
        exp_s  = model_step(exp_s, rst_ext_i, rst_jtag_i);
        chk_en = 1'b1;
    end

    // **************************************************
    // Stimulus tasks
    // **************************************************

    // Counts rising edges until core_rst_n_o is high, bounded by RELEASE_TIMEOUT.
    task automatic wait_core_release(input int want, input string what);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && (n < RELEASE_TIMEOUT)) begin
            @(posedge clk);
            @(negedge clk);
            n++;
            if (core_rst_n_o === 1'b1) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("Timeout: core reset still asserted %0d cycles after %s", n, what);
            to_cnt++;
        end else if (n != want) begin
            report_fail("core_rst_n_o release edges", 32'(n), 32'(want));
        end
    endtask

    // Cause is written one edge after the core release.
    task automatic cause_after_release(input rst_cause_e want);
        @(posedge clk);
        @(negedge clk);
        if (cause_o !== want) begin
            report_fail("cause_o", 32'(cause_o), 32'(want));
        end
    endtask

    // Debug request held for len sampled edges.
    task automatic debug_pulse(input int len);
        int k;
        @(posedge clk);
        rst_jtag_i <= 1'b1;
        for (k = 0; k < len; k++) begin
            @(posedge clk);
            if (k == len - 1) begin
                rst_jtag_i <= 1'b0;                             // This edge still samples high.
            end
            @(negedge clk);
            if (core_rst_n_o !== 1'b0) begin
                report_fail("core_rst_n_o", 32'(core_rst_n_o), 32'h0);
            end
            if (jtag_rst_n_o !== 1'b1) begin
                report_fail("jtag_rst_n_o", 32'(jtag_rst_n_o), 32'h1);
            end
        end
        wait_core_release(JTAG_RESET_FF_LEVELS_DEF, "debug request");
        cause_after_release(CAUSE_JTAG);
    endtask

    // External reset for cycles edges, optionally with a debug request on top.
    task automatic ext_reset_pulse(input int cycles, input logic overlap);
        @(posedge clk);
        rst_ext_i  <= 1'b0;
        rst_jtag_i <= overlap;
        repeat (cycles) @(posedge clk);
        @(negedge clk);
        if (core_rst_n_o !== 1'b0) begin
            report_fail("core_rst_n_o", 32'(core_rst_n_o), 32'h0);
        end
        if (jtag_rst_n_o !== 1'b0) begin
            report_fail("jtag_rst_n_o", 32'(jtag_rst_n_o), 32'h0);
        end
        if (cause_o !== CAUSE_NONE) begin
            report_fail("cause_o", 32'(cause_o), 32'(CAUSE_NONE));
        end
        if (jtag_cnt_o !== '0) begin
            report_fail("jtag_cnt_o", 32'(jtag_cnt_o), 32'h0);
        end
        @(posedge clk);
        rst_ext_i  <= 1'b1;
        rst_jtag_i <= 1'b0;
        wait_core_release(SYNC_STAGES_DEF, "external reset");
        if (jtag_rst_n_o !== 1'b1) begin
            report_fail("jtag_rst_n_o", 32'(jtag_rst_n_o), 32'h1);
        end
        cause_after_release(CAUSE_EXT);
    endtask

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin
        int len;
        int gap;
        int sel;
        int k;
        clk        = 1'b1;                                      // First falling edge at 4 ns.
        rst_ext_i  = 1'b0;
        rst_jtag_i = 1'b0;
        lfsr_q     = 32'h2dc2666f;
        err_cnt    = 0;
        to_cnt     = 0;
        chk_cnt    = 0;

        // Power-on reset, then release.
        repeat (5) @(posedge clk);
        rst_ext_i <= 1'b1;
        wait_core_release(SYNC_STAGES_DEF, "initial reset");
        if (jtag_rst_n_o !== 1'b1) begin
            report_fail("jtag_rst_n_o", 32'(jtag_rst_n_o), 32'h1);
        end
        cause_after_release(CAUSE_EXT);

        // Enough debug resets to saturate the counter.
        for (k = 0; k < 18; k++) begin
            draw_bits(3, len);
            draw_bits(4, gap);
            debug_pulse(len + 1);
            repeat (gap % 13) @(posedge clk);
        end
        @(negedge clk);
        if (jtag_cnt_o !== CNT_MAX) begin
            report_fail("jtag_cnt_o", 32'(jtag_cnt_o), 32'(CNT_MAX));
        end

        // Mid-run external resets, plain and with an overlapping request.
        ext_reset_pulse(3, 1'b0);
        debug_pulse(2);
        ext_reset_pulse(4, 1'b1);

        // Random mix of debug requests and external resets.
        for (k = 0; k < 60; k++) begin
            draw_bits(4, sel);
            draw_bits(3, len);
            draw_bits(4, gap);
            if (sel == 0) begin
                draw_bits(1, sel);
                ext_reset_pulse(len % 4 + 1, sel[0]);
            end else begin
                debug_pulse(len + 1);
            end
            repeat (gap % 13) @(posedge clk);
        end

        // Free-running inputs; only the model checks this part.
        for (k = 0; k < 300; k++) begin
            draw_bits(2, sel);
            draw_bits(6, gap);
            @(posedge clk);
            rst_jtag_i <= (sel == 3);
            rst_ext_i  <= (gap != 0);
        end
        @(posedge clk);
        rst_ext_i  <= 1'b1;
        rst_jtag_i <= 1'b0;
        repeat (20) @(posedge clk);
        @(negedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, to_cnt);
        if ((err_cnt == 0) && (to_cnt == 0) && (chk_cnt > 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_rst_subsys

// File: src.f
rtl/rst_cfg_pkg.sv
rtl/rst_types_pkg.sv
rtl/tick_sync_chain.sv
rtl/rst_ctrl.sv
rtl/rst_cause_rec.sv
rtl/rst_subsys_top.sv
sim/tb_rst_subsys.sv
